//--- hw/commit_pkg.sv
package commit_pkg;

  localparam int PC_W  = 32;
  localparam int CNT_W = 64;

  typedef logic [PC_W-1:0]  pc_t;
  typedef logic [CNT_W-1:0] cnt_t;

  localparam pc_t TRAP_VEC = 32'h0000_0100; // Fixed exception target.

  // Instruction lengths in bytes.
  localparam pc_t ILEN_32 = pc_t'(4);
  localparam pc_t ILEN_16 = pc_t'(2);

  // CSR write port select codes.
  localparam logic CSR_SEL_EPC = 1'b0;
  localparam logic CSR_SEL_DPC = 1'b1;

  typedef struct packed {
    pc_t             pc;
    logic [PC_W-1:0] imm;    // Sign-extended branch or jump offset.
    logic            rv32;   // 32-bit encoding, else compressed.
    logic            bjp;    // Branch or jump.
    logic            prdt;   // Predicted taken.
    logic            rslv;   // Resolved taken.
    logic            fencei;
    logic            mret;
    logic            dret;
    logic            excp;   // Item raised an exception.
  } commit_s;

  typedef struct packed {
    pc_t  target;
    logic excp;              // Trap redirect.
  } flush_s;

  typedef struct packed {
    logic sel;
    pc_t  data;
  } csr_wr_s;

endpackage

//--- hw/skid_buf.sv
`timescale 1ns/1ps

module skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t   entry_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  // Ready comes straight from the occupancy register.
  assign in_ready  = (cnt_q != 2'd2);
  assign out_valid = (cnt_q != 2'd0);
  assign out_data  = entry_q[rd_ptr_q];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entry_q[wr_ptr_q] <= in_data;
    end
  end

endmodule

//--- hw/branch_commit.sv
`timescale 1ns/1ps

module branch_commit (
  input  commit_pkg::commit_s item,
  input  commit_pkg::pc_t     epc,
  input  commit_pkg::pc_t     dpc,
  output logic                need_flush,
  output logic                is_excp,
  output commit_pkg::pc_t     op1,
  output commit_pkg::pc_t     op2
);

  import commit_pkg::*;

  logic mispredict;
  pc_t  ilen;

  assign mispredict = item.bjp & (item.prdt ^ item.rslv);
  assign ilen       = item.rv32 ? ILEN_32 : ILEN_16;

  // Only place where the exception condition is decoded.
  assign is_excp = item.excp;

  assign need_flush = mispredict
                    | item.fencei
                    | item.mret
                    | item.dret
                    | item.excp;

  // Base address of the redirect.
  always_comb begin
    if (item.dret) begin
      op1 = dpc;
    end else if (item.mret) begin
      op1 = epc;
    end else begin
      op1 = item.pc;
    end
  end

  // Offset added to the base.
  always_comb begin
    if (item.dret || item.mret) begin
      op2 = '0;
    end else if (item.fencei || item.prdt) begin
      op2 = ilen; // Fall through past this instruction.
    end else begin
      op2 = item.imm[PC_W-1:0];
    end
  end

endmodule

//--- hw/flush_ctrl.sv
`timescale 1ns/1ps

module flush_ctrl (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               item_valid,
  output logic               item_ready,
  input  logic               need_flush,
  input  logic               is_excp,
  input  commit_pkg::pc_t    op1,
  input  commit_pkg::pc_t    op2,
  output logic               flush_valid,
  input  logic               flush_ready,
  output commit_pkg::flush_s flush
);

  import commit_pkg::*;

  typedef enum logic {
    IDLE  = 1'b0,
    FLUSH = 1'b1
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   take_flush;
  flush_s flush_q;

  // Commit is held off while a redirect is outstanding.
  assign item_ready  = (state_q == IDLE);
  assign take_flush  = item_valid & item_ready & need_flush;
  assign flush_valid = (state_q == FLUSH);
  assign flush       = flush_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (take_flush) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        if (flush_ready) begin
          state_d = IDLE; // Fetch took the redirect.
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Target is captured once, on entry to FLUSH.
  always_ff @(posedge clk) begin
    if (take_flush) begin
      flush_q.target <= is_excp ? TRAP_VEC : op1 + op2;
      flush_q.excp   <= is_excp;
    end
  end

endmodule

//--- hw/retire_counter.sv
`timescale 1ns/1ps

module retire_counter (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             inc,
  output commit_pkg::cnt_t count
);

  import commit_pkg::*;

  cnt_t count_q;

  assign count = count_q;

  // Full-width add so the carry ripples into the upper word.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (inc) begin
      count_q <= count_q + CNT_W'(1);
    end
  end

endmodule

//--- hw/trap_csr.sv
`timescale 1ns/1ps

module trap_csr (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                excp_wr,
  input  commit_pkg::pc_t     excp_pc,
  input  logic                csr_valid,
  input  commit_pkg::csr_wr_s csr,
  output commit_pkg::pc_t     epc,
  output commit_pkg::pc_t     dpc
);

  import commit_pkg::*;

  pc_t  epc_q;
  pc_t  dpc_q;
  logic csr_epc_wr;
  logic csr_dpc_wr;

  // Clears bit 0 for halfword alignment.
  function automatic pc_t align_pc(input pc_t addr);
    return {addr[PC_W-1:1], 1'b0};
  endfunction

  assign csr_epc_wr = csr_valid & (csr.sel == CSR_SEL_EPC);
  assign csr_dpc_wr = csr_valid & (csr.sel == CSR_SEL_DPC);

  assign epc = epc_q;
  assign dpc = dpc_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      epc_q <= '0;
    end else if (excp_wr) begin
      epc_q <= align_pc(excp_pc); // Trap wins over software write.
    end else if (csr_epc_wr) begin
      epc_q <= align_pc(csr.data);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dpc_q <= '0;
    end else if (csr_dpc_wr) begin
      dpc_q <= align_pc(csr.data);
    end
  end

endmodule

//--- hw/commit_top.sv
`timescale 1ns/1ps

module commit_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cmt_valid,
  output logic                cmt_ready,
  input  commit_pkg::commit_s cmt,
  input  logic                csr_valid,
  output logic                csr_ready,
  input  commit_pkg::csr_wr_s csr,
  output logic                flush_valid,
  input  logic                flush_ready,
  output commit_pkg::flush_s  flush,
  output commit_pkg::cnt_t    instret
);

  import commit_pkg::*;

  commit_s item;
  logic    item_valid;
  logic    item_ready;
  logic    item_fire;
  csr_wr_s csr_item;
  logic    csr_item_valid;
  pc_t     epc;
  pc_t     dpc;
  pc_t     op1;
  pc_t     op2;
  logic    need_flush;
  logic    is_excp;

  assign item_fire = item_valid & item_ready;

  skid_buf #(.payload_t(commit_s)) u_cmt_buf (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (cmt_valid),
    .in_ready  (cmt_ready),
    .in_data   (cmt),
    .out_valid (item_valid),
    .out_ready (item_ready),
    .out_data  (item)
  );

  skid_buf #(.payload_t(csr_wr_s)) u_csr_buf (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (csr_valid),
    .in_ready  (csr_ready),
    .in_data   (csr),
    .out_valid (csr_item_valid),
    .out_ready (1'b1),          // CSR file never stalls.
    .out_data  (csr_item)
  );

  branch_commit u_branch (
    .item       (item),
    .epc        (epc),
    .dpc        (dpc),
    .need_flush (need_flush),
    .is_excp    (is_excp),
    .op1        (op1),
    .op2        (op2)
  );

  flush_ctrl u_flush (
    .clk         (clk),
    .arst_n      (arst_n),
    .item_valid  (item_valid),
    .item_ready  (item_ready),
    .need_flush  (need_flush),
    .is_excp     (is_excp),
    .op1         (op1),
    .op2         (op2),
    .flush_valid (flush_valid),
    .flush_ready (flush_ready),
    .flush       (flush)
  );

  // Excepting items do not retire.
  retire_counter u_cnt (
    .clk    (clk),
    .arst_n (arst_n),
    .inc    (item_fire & ~is_excp),
    .count  (instret)
  );

  trap_csr u_csr (
    .clk       (clk),
    .arst_n    (arst_n),
    .excp_wr   (item_fire & is_excp),
    .excp_pc   (item.pc),
    .csr_valid (csr_item_valid),
    .csr       (csr_item),
    .epc       (epc),
    .dpc       (dpc)
  );

endmodule

//--- sim/commit_checks.svh
`ifndef COMMIT_CHECKS_SVH
`define COMMIT_CHECKS_SVH

int checks_done = 0;

// Redirect seen on the flush channel against the scoreboard entry.
task automatic check_flush(input flush_s want, input flush_s got);
  if (got.target !== want.target) begin
    $display("FAIL flush.target expected %h got %h", want.target, got.target);
    abort_run();
  end else if (got.excp !== want.excp) begin
    $display("FAIL flush.excp expected %h got %h (target %h)",
             want.excp, got.excp, got.target);
    abort_run();
  end else begin
    checks_done++;
  end
endtask

// A flush with nothing pending means a duplicate or a spurious redirect.
task automatic check_flush_pending(input int pending, input flush_s got);
  if (pending == 0) begin
    $display("Flush to %h arrived while no redirect was expected", got.target);
    abort_run();
  end
endtask

// Retired-instruction count at a checkpoint.
task automatic check_count(input cnt_t want, input cnt_t got);
  if (got !== want) begin
    $display("FAIL instret expected %h got %h", want, got);
    abort_run();
  end else begin
    checks_done++;
  end
endtask

`endif

//--- sim/commit_tb.sv
`timescale 1ns/1ps

module commit_tb;

  import commit_pkg::*;

  localparam int          CLK_PERIOD      = 8;
  localparam int          DRIVE_DLY       = 1;
  localparam int          RESET_CYCLES    = 16;
  localparam int          CYCLES_PER_LINE = 40;
  localparam int          DRAIN_CYCLES    = 3;  // Two buffered items plus counter update.
  localparam logic [15:0] LFSR_SEED       = 16'd61830;
  localparam string       STIM_FILE       = "sim/commit_stimulus.txt";

  typedef struct packed {
    logic [7:0] kind;
    commit_s    cmt;
    csr_wr_s    csr;
    logic       exp_flush;
    flush_s     exp;
    cnt_t       exp_cnt;
  } line_s;

  logic    clk;
  logic    arst_n;
  logic    cmt_valid;
  logic    cmt_ready;
  commit_s cmt;
  logic    csr_valid;
  logic    csr_ready;
  csr_wr_s csr;
  logic    flush_valid;
  logic    flush_ready;
  flush_s  flush;
  cnt_t    instret;

  line_s  lines_q[$];
  flush_s flush_sb_q[$];  // Redirects still owed by the DUT, in commit order.

  commit_top u_commit_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmt_valid   (cmt_valid),
    .cmt_ready   (cmt_ready),
    .cmt         (cmt),
    .csr_valid   (csr_valid),
    .csr_ready   (csr_ready),
    .csr         (csr),
    .flush_valid (flush_valid),
    .flush_ready (flush_ready),
    .flush       (flush),
    .instret     (instret)
  );

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  `include "commit_checks.svh"

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic load_stimulus();
    int          fd;
    int          code;
    logic [7:0]  kind;
    string       skip;
    logic [31:0] f [13];
    line_s       rec;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open stimulus file %s", STIM_FILE);
      abort_run();
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) break;
      rec      = '0;
      rec.kind = kind;
      if (kind == "#") begin
        code = $fgets(skip, fd);  // Comment line.
      end else if (kind == "C") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                       f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        rec.cmt.pc     = f[0];
        rec.cmt.imm    = f[1];
        rec.cmt.rv32   = f[2][0];
        rec.cmt.bjp    = f[3][0];
        rec.cmt.prdt   = f[4][0];
        rec.cmt.rslv   = f[5][0];
        rec.cmt.fencei = f[6][0];
        rec.cmt.mret   = f[7][0];
        rec.cmt.dret   = f[8][0];
        rec.cmt.excp   = f[9][0];
        rec.exp_flush  = f[10][0];
        rec.exp.excp   = f[11][0];
        rec.exp.target = f[12];
        lines_q.push_back(rec);
      end else if (kind == "W") begin
        code = $fscanf(fd, "%h %h", f[0], f[1]);
        rec.csr.sel  = f[0][0];
        rec.csr.data = f[1];
        lines_q.push_back(rec);
      end else if (kind == "N") begin
        code = $fscanf(fd, "%h", f[0]);
        rec.exp_cnt = cnt_t'(f[0]);
        lines_q.push_back(rec);
      end else begin
        $display("Stimulus file has a line of unknown kind %c", kind);
        abort_run();
      end
    end
    $fclose(fd);
  endtask

  task automatic send_commit(input line_s rec);
    cmt       = rec.cmt;
    cmt_valid = 1'b1;
    while (!cmt_ready) step();
    step();                     // Transfer on this edge.
    cmt_valid = 1'b0;
    if (rec.exp_flush) begin
      flush_sb_q.push_back(rec.exp);
    end
  endtask

  task automatic send_csr(input csr_wr_s wr);
    csr       = wr;
    csr_valid = 1'b1;
    while (!csr_ready) step();
    step();
    csr_valid = 1'b0;
  endtask

  task automatic checkpoint(input cnt_t want);
    while (flush_sb_q.size() != 0) step();
    repeat (DRAIN_CYCLES) step();
    check_count(want, instret);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n      = 1'b0;
    cmt_valid   = 1'b0;
    cmt         = '0;
    csr_valid   = 1'b0;
    csr         = '0;
    flush_ready = 1'b0;
    load_stimulus();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    for (int i = 0; i < lines_q.size(); i++) begin
      case (lines_q[i].kind)
        "C":     send_commit(lines_q[i]);
        "W":     send_csr(lines_q[i].csr);
        default: checkpoint(lines_q[i].exp_cnt);
      endcase
    end
    while (flush_sb_q.size() != 0) step();
    $display("%0d compares matched", checks_done);
    $display("All checks passed");
    $finish;
  end

  // Fetch side. One LFSR bit per cycle decides whether a redirect is taken.
  initial begin : fetch_model
    logic [15:0] lfsr;
    lfsr = LFSR_SEED;
    @(posedge arst_n);
    forever begin
      step();
      lfsr        = lfsr_step(lfsr);
      flush_ready = lfsr[0];
    end
  end

  // Handshake values are stable at the falling edge.
  initial begin : flush_monitor
    flush_s want;
    forever begin
      @(negedge clk);
      if (arst_n && flush_valid && flush_ready) begin
        check_flush_pending(flush_sb_q.size(), flush);
        want = flush_sb_q.pop_front();
        check_flush(want, flush);
      end
    end
  end

  initial begin : watchdog
    int limit_ns;
    @(posedge arst_n);
    limit_ns = lines_q.size() * CYCLES_PER_LINE * CLK_PERIOD;
    #(limit_ns);
    $display("Run timed out after %0d ns of stimulus without finishing", limit_ns);
    abort_run();
  end

endmodule

//--- sim/commit_stimulus.txt
# C pc imm rv32 bjp prdt rslv fencei mret dret excp flush trap target | W sel data | N instret
# All fields hex. flush, trap and target give the redirect expected for a commit line.
# Plain instructions and correct predictions.
C 00001000 00000000 1 0 0 0 0 0 0 0 0 0 00000000
C 00001004 00000040 1 1 1 1 0 0 0 0 0 0 00000000
C 00001044 00000010 1 1 0 0 0 0 0 0 0 0 00000000
C 00001048 00000000 0 0 0 0 0 0 0 0 0 0 00000000
C 0000104a 0000001e 0 1 1 1 0 0 0 0 0 0 00000000
N 00000005
# Mispredictions and fence.i.
C 00002000 00000080 1 1 0 1 0 0 0 0 1 0 00002080
C 00002100 fffffff0 1 1 0 1 0 0 0 0 1 0 000020f0
C 00002200 00000100 1 1 1 0 0 0 0 0 1 0 00002204
C 00002302 00000100 0 1 1 0 0 0 0 0 1 0 00002304
C 00002400 00000000 1 0 0 0 1 0 0 0 1 0 00002404
N 0000000a
# Exceptions, mret and dret.
C 00003011 00000000 1 0 0 0 0 0 0 1 1 1 00000100
C 00003100 00000000 1 0 0 0 0 1 0 0 1 0 00003010
C 00003200 00000040 1 1 0 1 0 0 0 1 1 1 00000100
C 00003204 00000000 1 0 0 0 0 1 0 0 1 0 00003200
N 0000000c
W 0 00004567
C 00003208 00000000 1 0 0 0 0 1 0 0 1 0 00004566
W 1 00005003
C 0000320c 00000000 1 0 0 0 0 0 1 0 1 0 00005002
N 0000000e
# Back-to-back mix under fetch stalls.
C 00006000 00000020 1 1 0 1 0 0 0 0 1 0 00006020
C 00006020 00000000 1 0 0 0 0 0 0 0 0 0 00000000
C 00006024 00000000 1 0 0 0 0 0 0 1 1 1 00000100
C 00006028 00000008 0 1 1 0 0 0 0 0 1 0 0000602a
C 0000602a 00000000 1 0 0 0 1 0 0 0 1 0 0000602e
C 0000602e 00000000 1 0 0 0 0 1 0 0 1 0 00006024
C 00006100 ffffff00 1 1 0 1 0 0 0 0 1 0 00006000
C 00006104 00000000 0 0 0 0 0 0 1 0 1 0 00005002
N 00000015

//--- src.f
+incdir+sim
hw/commit_pkg.sv
hw/skid_buf.sv
hw/branch_commit.sv
hw/flush_ctrl.sv
hw/retire_counter.sv
hw/trap_csr.sv
hw/commit_top.sv
sim/commit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= commit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
